/* common/rom_map_pkg.sv */
`default_nettype none

// ==================================================
// Memory map of the OS ROM store
// ==================================================
package rom_map_pkg;

	// CPU side ROM address, bit 14 selects the OS window
	typedef logic [14:0] rom_addr_t;

	// Address inside one 16 KB slot
	typedef logic [13:0] slot_addr_t;
	localparam slot_addr_t SLOT_TOP = 14'h3FFF;

	typedef logic [7:0] rom_byte_t;

	// Returned for unloaded or unmapped addresses
	localparam rom_byte_t PAD_BYTE = 8'hFF;

	// Slot numbering
	typedef logic [1:0] slot_id_t;
	localparam slot_id_t SLOT_XL  = 2'd0;
	localparam slot_id_t SLOT_OSA = 2'd1;
	localparam slot_id_t SLOT_OSB = 2'd2;
	localparam int NUM_SLOTS = 3;

	// Machine code, 0 and 1 are XL, 2 is 800 with OS-A, 3 is 800 with OS-B
	typedef logic [1:0] machine_t;

endpackage

`default_nettype wire

/* common/rom_load_pkg.sv */
`default_nettype none

// ==================================================
// Loader protocol codes
// ==================================================
package rom_load_pkg;

	// Index byte that comes with each download
	typedef logic [7:0] load_index_t;

	// Menu load codes are matched on the low 6 bits of the index only
	typedef logic [5:0] load_code_t;
	localparam load_code_t IDX_XL  = 6'd4;
	localparam load_code_t IDX_OSA = 6'd6;
	localparam load_code_t IDX_OSB = 6'd7;

	// Boot default codes need a full 8 bit match
	// Only honoured while boot ROMs are enabled
	localparam load_index_t BOOT_XL  = 8'h00;
	localparam load_index_t BOOT_OSA = 8'h80;
	localparam load_index_t BOOT_OSB = 8'hC0;

endpackage

`default_nettype wire

/* common/rom_slot_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Write and read port of one OS ROM slot
interface rom_slot_if import rom_map_pkg::*; ();

	// Write side, driven by the loader decoder
	slot_addr_t wr_addr;
	rom_byte_t  wr_data;
	logic       wr_en;

	// Read side, address from the selector, data back from the slot
	slot_addr_t rd_addr;
	rom_byte_t  rd_data;
	logic       rd_hit;

	modport loader (
		output wr_addr,
		output wr_data,
		output wr_en
	);

	modport slot (
		input  wr_addr,
		input  wr_data,
		input  wr_en,
		input  rd_addr,
		output rd_data,
		output rd_hit
	);

	modport reader (
		output rd_addr,
		input  rd_data,
		input  rd_hit
	);

endinterface

`default_nettype wire

/* hdl/rom_load_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

// Turns loader writes into per-slot write strobes
module rom_load_decoder import rom_map_pkg::*, rom_load_pkg::*; #(
	parameter int N_SLOTS = 3
) (
	input  wire load_index_t ioctl_index_i,
	input  wire slot_addr_t  ioctl_addr_i,
	input  wire rom_byte_t   ioctl_data_i,
	input  wire logic        ioctl_wr_i,
	input  wire logic        boot_rom_en_i,
	rom_slot_if.loader       slot_o [N_SLOTS]
);

	// ==================================================
	// Code lookup per slot
	// ==================================================

	function automatic load_code_t idx_code(input int slot);
		case (slot)
			SLOT_XL:  return IDX_XL;
			SLOT_OSA: return IDX_OSA;
			default:  return IDX_OSB;
		endcase
	endfunction

	function automatic load_index_t boot_code(input int slot);
		case (slot)
			SLOT_XL:  return BOOT_XL;
			SLOT_OSA: return BOOT_OSA;
			default:  return BOOT_OSB;
		endcase
	endfunction

	// ==================================================
	// Strobe generation
	// ==================================================

	for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
		// Slots past OS-B have no load code and never get written
		localparam bit HAS_CODE = (g <= int'(SLOT_OSB));

		logic idx_hit;
		logic boot_hit;
		logic sel;

		assign idx_hit  = (ioctl_index_i[5:0] == idx_code(g));
		assign boot_hit = boot_rom_en_i && (ioctl_index_i == boot_code(g));
		assign sel      = HAS_CODE && (idx_hit || boot_hit);

		// Address and data fan out to every slot
		assign slot_o[g].wr_addr = ioctl_addr_i;
		assign slot_o[g].wr_data = ioctl_data_i;
		assign slot_o[g].wr_en   = ioctl_wr_i && sel;
	end

endmodule

`default_nettype wire

/* rom_bank/os_rom_slot.sv */
`timescale 1ns/10ps
`default_nettype none

// One 16 KB OS ROM slot
// A short image is stored from address 0 up, and the offset
// shifts it so the last byte sits at the top of the window
module os_rom_slot import rom_map_pkg::*; (
	input  wire logic clk_sys,
	input  wire logic areset,
	rom_slot_if.slot  bus
);

	// ==================================================
	// Storage
	// ==================================================

	rom_byte_t mem [0:SLOT_TOP];

	// Distance from the last written byte to the top of the window
	slot_addr_t offset;

	// Read address with the alignment offset removed
	slot_addr_t rd_index;

	assign rd_index = bus.rd_addr - offset;

	// Byte write port and registered read port
	always_ff @(posedge clk_sys) begin
		if (bus.wr_en) begin
			mem[bus.wr_addr] <= bus.wr_data;
		end
		bus.rd_data <= mem[rd_index];
	end

	// ==================================================
	// Offset and pad flag
	// ==================================================

	// Each write moves the offset, so the final one defines the image end
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			offset <= '0;
		end else if (bus.wr_en) begin
			offset <= SLOT_TOP - bus.wr_addr;
		end
	end

	// Addresses below the offset lie before the image start
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			bus.rd_hit <= 1'b0;
		end else begin
			bus.rd_hit <= (bus.rd_addr >= offset);
		end
	end

endmodule

`default_nettype wire

/* hdl/os_rom_select.sv */
`timescale 1ns/10ps
`default_nettype none

// Latches the machine choice during reset and picks the OS byte
module os_rom_select import rom_map_pkg::*; #(
	parameter int N_SLOTS = 3
) (
	input  wire logic      clk_sys,
	input  wire logic      areset,
	input  wire machine_t  machine_i,
	input  wire rom_addr_t rom_addr_i,
	rom_slot_if.reader     slot_i [N_SLOTS],
	output rom_byte_t      rom_data_o
);

	machine_t  machine_q;
	logic      win_hi_q;
	slot_id_t  sel;
	rom_byte_t slot_data [N_SLOTS];
	logic      slot_hit  [N_SLOTS];

	// ==================================================
	// Slot read ports
	// ==================================================

	for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
		assign slot_i[g].rd_addr = rom_addr_i[13:0];
		assign slot_data[g]      = slot_i[g].rd_data;
		assign slot_hit[g]       = slot_i[g].rd_hit;
	end

	// Machine choice follows machine_i only while reset is held
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			machine_q <= machine_i;
		end
	end

	// Window bit delayed to line up with the slot data
	always_ff @(posedge clk_sys) begin
		win_hi_q <= rom_addr_i[14];
	end

	// ==================================================
	// Output mux
	// ==================================================

	always_comb begin
		case (machine_q)
			2'd2:    sel = SLOT_OSA;
			2'd3:    sel = SLOT_OSB;
			default: sel = SLOT_XL;
		endcase
	end

	always_comb begin
		rom_data_o = PAD_BYTE;
		// Slot not built in this configuration keeps the pad byte
		if (win_hi_q && (int'(sel) < N_SLOTS)) begin
			if (slot_hit[sel]) begin
				rom_data_o = slot_data[sel];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/atari_os_rom.sv */
`timescale 1ns/10ps
`default_nettype none

// OS ROM store with three loadable images: XL, OS-A and OS-B
module atari_os_rom import rom_map_pkg::*, rom_load_pkg::*; #(
	parameter int N_SLOTS = NUM_SLOTS
) (
	input  wire logic        clk_sys,
	input  wire logic        areset,

	// Download port
	input  wire load_index_t ioctl_index_i,
	input  wire slot_addr_t  ioctl_addr_i,
	input  wire rom_byte_t   ioctl_data_i,
	input  wire logic        ioctl_wr_i,
	input  wire logic        boot_rom_en_i,

	// Machine select, sampled while in reset
	input  wire machine_t    machine_i,

	// CPU ROM port
	input  wire rom_addr_t   rom_addr_i,
	output rom_byte_t        rom_data_o
);

	// One bus per slot
	rom_slot_if slot_bus [N_SLOTS] ();

	// ==================================================
	// Loader side
	// ==================================================

	rom_load_decoder #(
		.N_SLOTS (N_SLOTS)
	) u_rom_load_decoder (
		.ioctl_index_i (ioctl_index_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_data_i  (ioctl_data_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.boot_rom_en_i (boot_rom_en_i),
		.slot_o        (slot_bus)
	);

	// ==================================================
	// ROM slots
	// ==================================================

	for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
		os_rom_slot u_os_rom_slot (
			.clk_sys (clk_sys),
			.areset  (areset),
			.bus     (slot_bus[g])
		);
	end

	// ==================================================
	// CPU side
	// ==================================================

	os_rom_select #(
		.N_SLOTS (N_SLOTS)
	) u_os_rom_select (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.machine_i  (machine_i),
		.rom_addr_i (rom_addr_i),
		.slot_i     (slot_bus),
		.rom_data_o (rom_data_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_atari_os_rom.sv */
`timescale 1ns/10ps
`default_nettype none

// Command file driven testbench for the OS ROM store
module tb_atari_os_rom import rom_map_pkg::*, rom_load_pkg::*; ();

	localparam int CLK_HALF     = 50;
	localparam int RESET_CYCLES = 3;
	localparam int READ_LATENCY = 1;
	localparam int RUN_TIMEOUT  = 100000;

	logic        clk_sys;
	logic        areset;
	load_index_t ioctl_index_i;
	slot_addr_t  ioctl_addr_i;
	rom_byte_t   ioctl_data_i;
	logic        ioctl_wr_i;
	logic        boot_rom_en_i;
	machine_t    machine_i;
	rom_addr_t   rom_addr_i;
	rom_byte_t   rom_data_o;

	// Name of the running test as given by the last label line
	logic [8*32-1:0] test_name;

	atari_os_rom #(
		.N_SLOTS (NUM_SLOTS)
	) u_atari_os_rom (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.ioctl_index_i (ioctl_index_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_data_i  (ioctl_data_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.boot_rom_en_i (boot_rom_en_i),
		.machine_i     (machine_i),
		.rom_addr_i    (rom_addr_i),
		.rom_data_o    (rom_data_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic fail_run(input string msg);
		$display("%0s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_byte(input rom_addr_t addr, input rom_byte_t expected,
			input rom_byte_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("CHECK FAILED %0s: addr %04h expected %02h actual %02h",
				test_name, addr, expected, actual));
		end
	endtask

	// Machine code is latched on every edge of the reset pulse
	task automatic apply_reset(input machine_t machine, input logic boot_en);
		int cycles;
		@(posedge clk_sys);
		areset        <= 1'b1;
		machine_i     <= machine;
		boot_rom_en_i <= boot_en;
		ioctl_wr_i    <= 1'b0;
		cycles = 0;
		while (cycles < RESET_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		areset <= 1'b0;
	endtask

	task automatic set_machine(input machine_t machine);
		@(posedge clk_sys);
		machine_i <= machine;
	endtask

	// Byte n of the image is start + n and goes to address n
	task automatic download(input load_index_t index, input int count, input rom_byte_t start);
		int n;
		if (count > int'(SLOT_TOP) + 1) begin
			fail_run($sformatf("download of %0d bytes does not fit in one slot", count));
		end
		for (n = 0; n < count; n++) begin
			@(posedge clk_sys);
			ioctl_index_i <= index;
			ioctl_wr_i    <= 1'b1;
			ioctl_addr_i  <= slot_addr_t'(n);
			ioctl_data_i  <= rom_byte_t'(int'(start) + n);
		end
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic read_and_check(input rom_addr_t addr, input rom_byte_t expected);
		int waited;
		@(posedge clk_sys);
		rom_addr_i <= addr;
		waited = 0;
		while (waited < READ_LATENCY) begin
			@(posedge clk_sys);
			waited++;
		end
		// Output settles after the edge so sample half a cycle later
		@(negedge clk_sys);
		check_byte(addr, expected, rom_data_o);
	endtask

	// ==================================================
	// Command file
	// ==================================================

	task automatic run_file(input int fd);
		logic [8*96-1:0] line_buf;
		logic [8*8-1:0]  cmd;
		logic [31:0]     a1;
		logic [31:0]     a2;
		logic [31:0]     a3;
		int              code;
		int              line_no;
		line_no = 0;
		while (!$feof(fd)) begin
			line_buf = '0;
			cmd      = '0;
			code     = $fgets(line_buf, fd);
			line_no++;
			if (code > 0) begin
				code = $sscanf(line_buf, "%s", cmd);
			end
			case (cmd)
				"T": begin
					code = $sscanf(line_buf, "%s %s", cmd, test_name);
					$display("running %0s", test_name);
				end
				"X": begin
					code = $sscanf(line_buf, "%s %h %h", cmd, a1, a2);
					if (code != 3) fail_run($sformatf("reset line %0d is incomplete", line_no));
					apply_reset(machine_t'(a1), a2[0]);
				end
				"D": begin
					code = $sscanf(line_buf, "%s %h %h %h", cmd, a1, a2, a3);
					if (code != 4) fail_run($sformatf("download line %0d is incomplete", line_no));
					download(load_index_t'(a1), int'(a2), rom_byte_t'(a3));
				end
				"M": begin
					code = $sscanf(line_buf, "%s %h", cmd, a1);
					if (code != 2) fail_run($sformatf("machine line %0d is incomplete", line_no));
					set_machine(machine_t'(a1));
				end
				"R": begin
					code = $sscanf(line_buf, "%s %h %h", cmd, a1, a2);
					if (code != 3) fail_run($sformatf("read line %0d is incomplete", line_no));
					read_and_check(rom_addr_t'(a1), rom_byte_t'(a2));
				end
				// Comment and blank lines
				"#", '0: ;
				default: fail_run($sformatf("unknown command on line %0d", line_no));
			endcase
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		int fd;
		areset        = 1'b1;
		ioctl_index_i = '0;
		ioctl_addr_i  = '0;
		ioctl_data_i  = '0;
		ioctl_wr_i    = 1'b0;
		boot_rom_en_i = 1'b0;
		machine_i     = '0;
		rom_addr_i    = '0;
		test_name     = "startup";
		fd = $fopen("testbench/os_rom_input.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open testbench/os_rom_input.txt");
		end else begin
			run_file(fd);
			$fclose(fd);
			$display("all tests passed");
			$finish;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < RUN_TIMEOUT) begin
			@(posedge clk_sys);
			cycles++;
		end
		fail_run("simulation ran past its cycle limit");
	end

endmodule

`default_nettype wire

/* testbench/os_rom_input.txt */
# cmd: T name | X machine boot_en | D index count start | M machine | R rom_addr expected
# numbers in hex; D writes count bytes from address 0, byte n is (start + n) mod 256
T full_xl_load
X 0 0
D 04 4000 37
R 4000 37
R 4001 38
R 40c8 ff
R 40c9 00
R 5a5a 91
R 7fff 36
T partial_osa_load
X 2 0
D 06 2800 11
R 5800 11
R 5801 12
R 6003 14
R 7fff 10
R 57ff ff
R 4000 ff
T latched_machine
X 3 0
D 07 2000 5a
R 6000 5a
R 7fff 59
R 5fff ff
M 0
R 6001 5b
M 2
R 7000 5a
X 2 0
R 4000 11
R 4025 36
T lower_window
X 0 0
R 0000 ff
R 3fff ff
X 1 0
R 1234 ff
X 2 0
R 2000 ff
X 3 0
R 0abc ff
T boot_defaults
X 3 1
D c0 1000 a0
R 7000 a0
R 7fff 9f
R 6fff ff
X 3 0
D c0 1000 00
R 4000 a0
R 4010 b0
R 5000 5a

/* project.f */
common/rom_map_pkg.sv
common/rom_load_pkg.sv
common/rom_slot_if.sv
hdl/rom_load_decoder.sv
rom_bank/os_rom_slot.sv
hdl/os_rom_select.sv
hdl/atari_os_rom.sv
testbench/tb_atari_os_rom.sv

/* Makefile */
TOP = tb_atari_os_rom

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
